// ==== compile.f ====
hdl/SweepPkg.sv
hdl/WindowTimer.sv
hdl/TriggerCounter.sv
hdl/ModeSwitcher.sv
hdl/SweepFsm.sv
hdl/ControllerTop.sv
testbench/SweepFsm_properties.sv
testbench/ControllerTb.sv

// ==== hdl/ControllerTop.sv ====
module ControllerTop #(
    parameter int windowCycles = 64
) (
    input  logic                 Clk,
    input  logic                 rstN,
    // Mode and DAC choice
    input  logic                 sweepMode,
    input  SweepPkg::dacSelT     dacSelect,
    // Host slow control
    input  SweepPkg::dacSetT     usbDacs,
    input  logic                 usbScLoad,
    input  SweepPkg::sweepRangeT range,
    input  logic                 sweepStartIn,
    // ASIC side
    input  logic                 configDone,
    input  logic                 triggerN,
    input  SweepPkg::usbBeatT    acqBeat,
    output SweepPkg::dacSetT     dacOut,
    output logic                 scLoad,
    // USB FIFO side
    output SweepPkg::usbBeatT    usbOut,
    output logic                 sweepDone
);
    import SweepPkg::*;

    logic    sweepStart;
    dacT     curDac;
    logic    sweepLoad;
    logic    timerStart;
    logic    countClear;
    usbBeatT sweepBeat;
    logic    countEnable;
    logic    windowDone;
    countT   count;

    ModeSwitcher switcher (
        .Clk          (Clk),
        .rstN         (rstN),
        .sweepMode    (sweepMode),
        .dacSelect    (dacSelect),
        .usbDacs      (usbDacs),
        .curDac       (curDac),
        .usbScLoad    (usbScLoad),
        .sweepLoad    (sweepLoad),
        .sweepStartIn (sweepStartIn),
        .acqBeat      (acqBeat),
        .sweepBeat    (sweepBeat),
        .dacOut       (dacOut),
        .scLoad       (scLoad),
        .sweepStart   (sweepStart),
        .usbOut       (usbOut)
    );

    //////////////////////////////
    // Sweep engine
    //////////////////////////////

    SweepFsm #(
        .windowCycles (windowCycles)
    ) fsm (
        .Clk        (Clk),
        .rstN       (rstN),
        .sweepStart (sweepStart),
        .range      (range),
        .configDone (configDone),
        .windowDone (windowDone),
        .count      (count),
        .curDac     (curDac),
        .sweepLoad  (sweepLoad),
        .timerStart (timerStart),
        .countClear (countClear),
        .sweepBeat  (sweepBeat),
        .sweepDone  (sweepDone)
    );

    WindowTimer #(
        .windowCycles (windowCycles)
    ) timer (
        .Clk         (Clk),
        .rstN        (rstN),
        .timerStart  (timerStart),
        .countEnable (countEnable),
        .windowDone  (windowDone)
    );

    TriggerCounter trigCounter (
        .Clk         (Clk),
        .rstN        (rstN),
        .triggerN    (triggerN),
        .countClear  (countClear),
        .countEnable (countEnable),
        .count       (count)
    );

endmodule

// ==== hdl/ModeSwitcher.sv ====
module ModeSwitcher (
    input  logic              Clk,
    input  logic              rstN,
    input  logic              sweepMode,
    input  SweepPkg::dacSelT  dacSelect,
    input  SweepPkg::dacSetT  usbDacs,
    input  SweepPkg::dacT     curDac,
    input  logic              usbScLoad,
    input  logic              sweepLoad,
    input  logic              sweepStartIn,
    input  SweepPkg::usbBeatT acqBeat,
    input  SweepPkg::usbBeatT sweepBeat,
    output SweepPkg::dacSetT  dacOut,
    output logic              scLoad,
    output logic              sweepStart,
    output SweepPkg::usbBeatT usbOut
);
    import SweepPkg::*;

    usbBeatT beatSel;

    //////////////////////////////
    // Slow control path
    //////////////////////////////

    // Sweep replaces only the selected DAC
    always_comb begin
        dacOut = usbDacs;
        if (sweepMode) begin
            case (dacSelect)
                2'd0:    dacOut.dac0 = curDac;
                2'd1:    dacOut.dac1 = curDac;
                2'd2:    dacOut.dac2 = curDac;
                // Select 3 keeps all host values
                default: dacOut = usbDacs;
            endcase
        end
    end

    assign scLoad     = sweepMode ? sweepLoad : usbScLoad;
    assign sweepStart = sweepMode && sweepStartIn;

    //////////////////////////////
    // USB data path
    //////////////////////////////

    assign beatSel = sweepMode ? sweepBeat : acqBeat;

    always_ff @(posedge Clk or negedge rstN) begin
        if (!rstN) begin
            usbOut <= '0;
        end else begin
            usbOut <= beatSel;
        end
    end

endmodule

// ==== hdl/SweepFsm.sv ====
module SweepFsm #(
    parameter int windowCycles = 64
) (
    input  logic                 Clk,
    input  logic                 rstN,
    input  logic                 sweepStart,
    input  SweepPkg::sweepRangeT range,
    input  logic                 configDone,
    input  logic                 windowDone,
    input  SweepPkg::countT      count,
    output SweepPkg::dacT        curDac,
    output logic                 sweepLoad,
    output logic                 timerStart,
    output logic                 countClear,
    output SweepPkg::usbBeatT    sweepBeat,
    output logic                 sweepDone
);
    import SweepPkg::*;

    typedef enum logic [2:0] {
        idle,
        load,
        waitConfig,
        counting,
        header,
        data,
        finish
    } stateT;

    stateT state;
    stateT stateNext;
    logic  lastStep;

    assign lastStep = (curDac == range.endDac);

    //////////////////////////////
    // Step order
    //////////////////////////////

    always_comb begin
        stateNext = state;
        case (state)
            idle: begin
                // Empty range goes straight to done
                if (sweepStart) begin
                    stateNext = (range.startDac > range.endDac) ? finish : load;
                end
            end
            load:       stateNext = waitConfig;
            waitConfig: begin
                if (configDone) begin
                    stateNext = counting;
                end
            end
            counting: begin
                if (windowDone) begin
                    stateNext = header;
                end
            end
            header:     stateNext = data;
            data:       stateNext = lastStep ? finish : load;
            finish:     stateNext = idle;
            default:    stateNext = idle;
        endcase
    end

    always_ff @(posedge Clk or negedge rstN) begin
        if (!rstN) begin
            state      <= idle;
            timerStart <= 1'b0;
        end else begin
            state      <= stateNext;
            // Window opens the cycle after configDone
            timerStart <= (state == waitConfig) && configDone;
        end
    end

    // Current DAC step
    always_ff @(posedge Clk or negedge rstN) begin
        if (!rstN) begin
            curDac <= '0;
        end else if ((state == idle) && sweepStart) begin
            curDac <= range.startDac;
        end else if ((state == data) && !lastStep) begin
            curDac <= curDac + 1'b1;
        end
    end

    //////////////////////////////
    // Strobes and output words
    //////////////////////////////

    assign sweepLoad  = (state == load);
    assign sweepDone  = (state == finish);
    assign countClear = timerStart;

    always_comb begin
        sweepBeat = '0;
        case (state)
            header: begin
                sweepBeat.word = {headerTag, curDac};
                sweepBeat.en   = 1'b1;
            end
            data: begin
                sweepBeat.word = count;
                sweepBeat.en   = 1'b1;
            end
            default: sweepBeat = '0;
        endcase
    end

endmodule

// ==== hdl/SweepPkg.sv ====
package SweepPkg;

    //////////////////////////////
    // Widths with a meaning
    //////////////////////////////

    // Discriminator threshold code
    typedef logic [9:0] dacT;

    // Saturating trigger count
    typedef logic [15:0] countT;

    // One word on the USB FIFO port
    typedef logic [15:0] usbWordT;

    // Picks dac0, dac1 or dac2, value 3 picks none
    typedef logic [1:0] dacSelT;

    //////////////////////////////
    // Bundles
    //////////////////////////////

    typedef struct packed {
        dacT dac0;
        dacT dac1;
        dacT dac2;
    } dacSetT;

    typedef struct packed {
        usbWordT word;
        logic    en;
    } usbBeatT;

    // Inclusive sweep bounds
    typedef struct packed {
        dacT startDac;
        dacT endDac;
    } sweepRangeT;

    // Upper bits of the header word, DAC code fills the rest
    localparam logic [5:0] headerTag = 6'b101010;

endpackage

// ==== hdl/TriggerCounter.sv ====
module TriggerCounter (
    input  logic            Clk,
    input  logic            rstN,
    input  logic            triggerN,
    input  logic            countClear,
    input  logic            countEnable,
    output SweepPkg::countT count
);

    logic syncQ1;
    logic syncQ2;
    logic prevQ;
    logic fallEdge;

    //////////////////////////////
    // Pin synchronizer
    //////////////////////////////

    // Idle level of the pin is high
    always_ff @(posedge Clk or negedge rstN) begin
        if (!rstN) begin
            syncQ1 <= 1'b1;
            syncQ2 <= 1'b1;
            prevQ  <= 1'b1;
        end else begin
            syncQ1 <= triggerN;
            syncQ2 <= syncQ1;
            prevQ  <= syncQ2;
        end
    end

    // High to low on the synced pin
    assign fallEdge = prevQ && !syncQ2;

    //////////////////////////////
    // Count with saturation
    //////////////////////////////

    always_ff @(posedge Clk or negedge rstN) begin
        if (!rstN) begin
            count <= '0;
        end else if (countClear) begin
            count <= '0;
        end else if (countEnable && fallEdge && (count != '1)) begin
            count <= count + 1'b1;
        end
    end

endmodule

// ==== hdl/WindowTimer.sv ====
module WindowTimer #(
    parameter int windowCycles = 64
) (
    input  logic Clk,
    input  logic rstN,
    input  logic timerStart,
    output logic countEnable,
    output logic windowDone
);

    localparam int timerW = $clog2(windowCycles + 1);

    logic [timerW-1:0] remaining;

    // Cycles left in the window
    always_ff @(posedge Clk or negedge rstN) begin
        if (!rstN) begin
            remaining <= '0;
        end else if (timerStart) begin
            remaining <= timerW'(windowCycles);
        end else if (remaining != '0) begin
            remaining <= remaining - 1'b1;
        end
    end

    // Pulses in the first cycle after the last enabled one
    always_ff @(posedge Clk or negedge rstN) begin
        if (!rstN) begin
            windowDone <= 1'b0;
        end else begin
            windowDone <= (remaining == timerW'(1)) && !timerStart;
        end
    end

    assign countEnable = (remaining != '0);

endmodule

// ==== run.sh ====
#!/bin/sh
# Build with Verilator, run, and decide pass or fail from the log
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module ControllerTb -f compile.f \
    && ./obj_dir/VControllerTb > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "^Regression passed$" sim.log && exit 0 || exit 1

// ==== testbench/ControllerTb.sv ====
module ControllerTb;
    import SweepPkg::*;

    localparam int windowCycles = 32;
    // Worst step is load, config delay of 9, window and two beats with slack
    localparam int stepCycles    = 2 + 9 + windowCycles + 10;
    localparam int timeoutCycles = 60 + 6 * stepCycles + 80;
    localparam logic [5:0] tagBits = 6'b101010;

    logic       Clk = 1'b0;
    logic       rstN;
    logic       sweepMode;
    dacSelT     dacSelect;
    dacSetT     usbDacs;
    logic       usbScLoad;
    sweepRangeT range;
    logic       sweepStartIn;
    logic       configDone;
    logic       triggerN;
    usbBeatT    acqBeat;
    dacSetT     dacOut;
    logic       scLoad;
    usbBeatT    usbOut;
    logic       sweepDone;

    logic [15:0] lfsr = 16'd51647;
    int          cycleCount = 0;
    int          errorCount = 0;

    ControllerTop #(
        .windowCycles (windowCycles)
    ) dut (
        .Clk          (Clk),
        .rstN         (rstN),
        .sweepMode    (sweepMode),
        .dacSelect    (dacSelect),
        .usbDacs      (usbDacs),
        .usbScLoad    (usbScLoad),
        .range        (range),
        .sweepStartIn (sweepStartIn),
        .configDone   (configDone),
        .triggerN     (triggerN),
        .acqBeat      (acqBeat),
        .dacOut       (dacOut),
        .scLoad       (scLoad),
        .usbOut       (usbOut),
        .sweepDone    (sweepDone)
    );

    initial begin
        forever #20 Clk = ~Clk;
    end

    always @(posedge Clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount > timeoutCycles) begin
            $display("Timeout after %0d cycles, the DUT stopped responding", cycleCount);
            $display("Regression failed");
            $fatal(1, "Watchdog expired");
        end
    end

    //////////////////////////////
    // Random source and checks
    //////////////////////////////

    // Galois LFSR, one step per bit
    function automatic logic [15:0] randBits(input int n);
        logic [15:0] value;
        logic        outBit;
        value = '0;
        for (int i = 0; i < n; i++) begin
            outBit = lfsr[0];
            lfsr   = lfsr >> 1;
            if (outBit) begin
                lfsr = lfsr ^ 16'hB400;
            end
            value = {value[14:0], outBit};
        end
        return value;
    endfunction

    task automatic reportFailure(input string what);
        errorCount++;
        $display("%s", what);
        $display("Regression failed");
        $fatal(1, "Stopped at first error");
    endtask

    task automatic checkBit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            reportFailure($sformatf("FAIL t=%0t %s got %b expected %b", $time, name, got, exp));
        end
    endtask

    task automatic checkDac(input string name, input dacSetT got, input dacSetT exp);
        if (got !== exp) begin
            reportFailure($sformatf("FAIL t=%0t %s got %h %h %h expected %h %h %h", $time, name,
                got.dac0, got.dac1, got.dac2, exp.dac0, exp.dac1, exp.dac2));
        end
    endtask

    task automatic checkBeat(input string name, input usbBeatT got, input usbBeatT exp);
        if (got !== exp) begin
            reportFailure($sformatf("FAIL t=%0t %s got word %h en %b expected word %h en %b",
                $time, name, got.word, got.en, exp.word, exp.en));
        end
    endtask

    // Host DACs with the swept one replaced, select 3 replaces none
    function automatic dacSetT expectedDacs(input dacSetT host, input dacSelT sel,
                                            input dacT step);
        dacSetT result;
        result = host;
        case (sel)
            2'd0:    result.dac0 = step;
            2'd1:    result.dac1 = step;
            2'd2:    result.dac2 = step;
            default: result = host;
        endcase
        return result;
    endfunction

    task automatic waitLoadOrDone;
        while (!scLoad && !sweepDone) begin
            @(negedge Clk);
        end
    endtask

    // ASIC takes 2 to 9 cycles to load its config
    task automatic answerConfigLoad;
        int delay;
        delay = 2 + int'(randBits(3));
        repeat (delay) begin
            @(negedge Clk);
            checkBit("scLoad", scLoad, 1'b0);
            checkBeat("usbOut", usbOut, '0);
        end
        configDone = 1'b1;
        @(negedge Clk);
        configDone = 1'b0;
    endtask

    //////////////////////////////
    // Directed tests
    //////////////////////////////

    task automatic testNormalPassthrough;
        sweepMode = 1'b0;
        for (int i = 0; i < 20; i++) begin
            acqBeat.word = randBits(16);
            acqBeat.en   = randBits(1);
            usbDacs.dac0 = dacT'(randBits(10));
            usbDacs.dac1 = dacT'(randBits(10));
            usbDacs.dac2 = dacT'(randBits(10));
            // Keep the host load a single-cycle strobe
            usbScLoad    = !usbScLoad && randBits(1);
            @(negedge Clk);
            checkBeat("usbOut", usbOut, acqBeat);
            checkDac("dacOut", dacOut, usbDacs);
            checkBit("scLoad", scLoad, usbScLoad);
        end
        usbScLoad = 1'b0;
    endtask

    task automatic testIgnoredStart;
        // Empty range, so a start that slips through shows up as sweepDone
        sweepMode      = 1'b0;
        range.startDac = dacT'(1);
        range.endDac   = dacT'(0);
        sweepStartIn   = 1'b1;
        @(negedge Clk);
        sweepStartIn = 1'b0;
        repeat (4) begin
            checkBit("scLoad", scLoad, 1'b0);
            checkBit("sweepDone", sweepDone, 1'b0);
            @(negedge Clk);
        end
    endtask

    task automatic runSweep(input dacT startDac, input dacT endDac, input dacSelT sel,
                            input bit lateTrigger);
        dacT     stepDac;
        int      stepTotal;
        int      nPulses;
        int      elapsed;
        usbBeatT expBeat;
        stepDac        = startDac;
        stepTotal      = int'(endDac) - int'(startDac) + 1;
        sweepMode      = 1'b1;
        dacSelect      = sel;
        range.startDac = startDac;
        range.endDac   = endDac;
        usbDacs.dac0   = dacT'(randBits(10));
        usbDacs.dac1   = dacT'(randBits(10));
        usbDacs.dac2   = dacT'(randBits(10));
        // Acquisition data that must stay off the USB port
        acqBeat.word   = randBits(16);
        acqBeat.en     = 1'b1;
        @(negedge Clk);
        sweepStartIn = 1'b1;
        @(negedge Clk);
        sweepStartIn = 1'b0;
        for (int step = 0; step < stepTotal; step++) begin
            waitLoadOrDone();
            checkBit("sweepDone", sweepDone, 1'b0);
            checkDac("dacOut", dacOut, expectedDacs(usbDacs, sel, stepDac));
            answerConfigLoad();
            repeat (3) @(negedge Clk);
            elapsed = 4;
            if (step == 0) begin
                nPulses = 0;
            end else if (step == 1) begin
                nPulses = 5;
            end else begin
                nPulses = int'(randBits(3)) % 6;
            end
            repeat (nPulses) begin
                triggerN = 1'b0;
                repeat (2) @(negedge Clk);
                triggerN = 1'b1;
                repeat (2) @(negedge Clk);
                elapsed += 4;
            end
            // Edge lands after the window has closed
            if (lateTrigger) begin
                repeat (windowCycles + 1 - elapsed) @(negedge Clk);
                triggerN = 1'b0;
                repeat (2) @(negedge Clk);
                triggerN = 1'b1;
            end
            while (!usbOut.en) begin
                @(negedge Clk);
            end
            expBeat.word = {tagBits, stepDac};
            expBeat.en   = 1'b1;
            checkBeat("usbOut header", usbOut, expBeat);
            @(negedge Clk);
            expBeat.word = usbWordT'(nPulses);
            checkBeat("usbOut count", usbOut, expBeat);
            stepDac = stepDac + dacT'(1);
        end
        waitLoadOrDone();
        checkBit("sweepDone", sweepDone, 1'b1);
        checkBit("scLoad", scLoad, 1'b0);
        @(negedge Clk);
        checkBit("sweepDone", sweepDone, 1'b0);
        checkBeat("usbOut", usbOut, '0);
    endtask

    task automatic testEmptyRange;
        sweepMode      = 1'b1;
        dacSelect      = 2'd0;
        range.startDac = dacT'(200);
        range.endDac   = dacT'(150);
        @(negedge Clk);
        sweepStartIn = 1'b1;
        @(negedge Clk);
        sweepStartIn = 1'b0;
        checkBit("sweepDone", sweepDone, 1'b1);
        checkBit("scLoad", scLoad, 1'b0);
        checkBit("usbOut.en", usbOut.en, 1'b0);
        repeat (4) begin
            @(negedge Clk);
            checkBit("sweepDone", sweepDone, 1'b0);
            checkBit("scLoad", scLoad, 1'b0);
            checkBit("usbOut.en", usbOut.en, 1'b0);
        end
    endtask

    initial begin
        rstN         = 1'b0;
        sweepMode    = 1'b0;
        dacSelect    = '0;
        usbDacs      = '0;
        usbScLoad    = 1'b0;
        range        = '0;
        sweepStartIn = 1'b0;
        configDone   = 1'b0;
        triggerN     = 1'b1;
        acqBeat      = '0;
        repeat (3) @(negedge Clk);
        checkBit("scLoad", scLoad, 1'b0);
        checkBit("sweepDone", sweepDone, 1'b0);
        checkBeat("usbOut", usbOut, '0);
        rstN = 1'b1;

        testNormalPassthrough();
        testIgnoredStart();
        runSweep(dacT'(100), dacT'(102), 2'd1, 1'b0);
        runSweep(dacT'(100), dacT'(102), 2'd3, 1'b1);
        testEmptyRange();

        if (errorCount == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// ==== testbench/SweepFsm_properties.sv ====
module SweepFsmProperties (
    input logic Clk,
    input logic rstN,
    input logic sweepLoad,
    input logic sweepDone,
    input logic timerStart,
    input logic countClear,
    input logic beatEn,
    input logic inIdle
);

    //////////////////////////////
    // Strobe rules
    //////////////////////////////

    loadDoneExclusive: assert property (@(posedge Clk) disable iff (!rstN)
        !(sweepLoad && sweepDone))
        else $error("sweepLoad and sweepDone high in the same cycle");

    loadOneCycle: assert property (@(posedge Clk) disable iff (!rstN)
        sweepLoad |=> !sweepLoad)
        else $error("sweepLoad held longer than one cycle");

    doneOneCycle: assert property (@(posedge Clk) disable iff (!rstN)
        sweepDone |=> !sweepDone)
        else $error("sweepDone held longer than one cycle");

    timerOneCycle: assert property (@(posedge Clk) disable iff (!rstN)
        timerStart |=> !timerStart)
        else $error("timerStart held longer than one cycle");

    clearOneCycle: assert property (@(posedge Clk) disable iff (!rstN)
        countClear |=> !countClear)
        else $error("countClear held longer than one cycle");

    // No output words while idle
    noBeatInIdle: assert property (@(posedge Clk) disable iff (!rstN)
        inIdle |-> !beatEn)
        else $error("sweepBeat.en high in idle");

endmodule

bind SweepFsm SweepFsmProperties props (
    .Clk        (Clk),
    .rstN       (rstN),
    .sweepLoad  (sweepLoad),
    .sweepDone  (sweepDone),
    .timerStart (timerStart),
    .countClear (countClear),
    .beatEn     (sweepBeat.en),
    .inIdle     (state == idle)
);
